//--- Makefile
TOP := correlator_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f sim.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

//--- logic/bit_decoder.sv
`timescale 1ns/1ns

module bit_decoder import corr_pkg::*; (
	input  logic             clk,	// system clock
	input  logic             rst_b,	// async reset, low active
	input  logic             coh_finished_i,	// coherent sum ready
	input  iq_acc_t          coh_sum_i,	// coherent sum, i upper
	input  logic             data_in_q_i,	// data on the Q branch
	input  decode_cfg_t      decode_cfg_i,	// width and shift settings
	output logic [DEC_W-1:0] decode_data_o	// decoded bits, newest at lsb
);

	logic signed [ACC_W-1:0] data_sel;	// chosen half
	logic [2:0]              len_idx;	// from bit length
	logic [2:0]              shift_tot;	// pre + post + 1
	logic [2:0]              bit_sel;	// extra right shift
	logic [7:0]              dec2;	// quantized fields, low bits used
	logic [7:0]              dec4;
	logic [7:0]              dec8;
	logic [DEC_W-1:0]        dec_next;	// register after the shift

	// shift right, then clip to w signed bits
	function automatic logic [7:0] quantize(input logic signed [ACC_W-1:0] v,
		input int w, input logic [2:0] s);
		logic signed [ACC_W-1:0] shifted;
		logic signed [ACC_W-1:0] hi;
		logic signed [ACC_W-1:0] lo;
		hi      = ACC_W'((1 << (w - 1)) - 1);	// largest w-bit value
		lo      = -hi - 16'sd1;
		shifted = v >>> (ACC_W - w - s);	// truncates
		if (shifted > hi)
			quantize = hi[7:0];	// positive saturation
		else if (shifted < lo)
			quantize = lo[7:0];	// negative saturation
		else
			quantize = shifted[7:0];
	endfunction

	//----------------------------------------------------------------------
	// field selection and quantization
	//----------------------------------------------------------------------
	assign data_sel  = data_in_q_i ? coh_sum_i.q : coh_sum_i.i;
	assign len_idx   = decode_cfg_i.bit_length[4] ? 3'd2 : (decode_cfg_i.bit_length[3] ? 3'd1 : 3'd0);
	assign shift_tot = {1'b0, decode_cfg_i.pre_shift} + {1'b0, decode_cfg_i.post_shift} + 3'd1;
	assign bit_sel   = (shift_tot >= len_idx) ? (shift_tot - len_idx) : 3'd0;

	assign dec2 = quantize(data_sel, 2, bit_sel);
	assign dec4 = quantize(data_sel, 4, bit_sel);
	assign dec8 = quantize(data_sel, 8, bit_sel);

	always_comb
	begin
		case (decode_cfg_i.decode_bit)
			2'd0: dec_next = {decode_data_o[DEC_W-2:0], data_sel[ACC_W-1]};	// sign only
			2'd1: dec_next = {decode_data_o[DEC_W-3:0], dec2[1:0]};
			2'd2: dec_next = {decode_data_o[DEC_W-5:0], dec4[3:0]};
			default: dec_next = {decode_data_o[DEC_W-9:0], dec8};
		endcase
	end

	//----------------------------------------------------------------------
	// decoded data shift register
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
			decode_data_o <= '0;
		else if (coh_finished_i)
			decode_data_o <= dec_next;	// one cycle latency
	end

endmodule

//--- logic/code_nco.sv
`timescale 1ns/1ns

module code_nco import corr_pkg::*; #(
	parameter int NUM_COR = 8	// number of half-chip taps
) (
	input  logic               clk,	// system clock
	input  logic               rst_b,	// async reset, low active
	input  logic               sample_valid_i,	// one nco step per sample
	input  logic [PHASE_W-1:0] code_freq_i,	// phase increment, <= 2^31
	input  logic               prn_chip_i,	// current prn chip
	output logic               half_chip_o,	// carry of the phase accumulator
	output logic               chip_shift_o,	// request for next chip
	output logic [NUM_COR-1:0] taps_o	// delayed chip copies
);

	logic [PHASE_W-1:0] phase_q;	// code phase
	logic [PHASE_W:0]   phase_sum;	// phase plus increment, msb is carry
	logic               sub_phase_q;	// half-chip parity
	logic [NUM_COR-1:0] taps_q;	// chip delay line, tap 0 newest

	//----------------------------------------------------------------------
	// phase accumulator and boundary strobes
	//----------------------------------------------------------------------
	assign phase_sum    = {1'b0, phase_q} + {1'b0, code_freq_i};
	assign half_chip_o  = sample_valid_i & phase_sum[PHASE_W];	// carry only on a sample
	assign chip_shift_o = half_chip_o & sub_phase_q;	// every second boundary
	assign taps_o       = taps_q;

	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
			phase_q <= '0;
		else if (sample_valid_i)
			phase_q <= phase_sum[PHASE_W-1:0];	// wraps
	end

	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
			sub_phase_q <= 1'b0;
		else if (half_chip_o)
			sub_phase_q <= ~sub_phase_q;
	end

	//----------------------------------------------------------------------
	// half-chip spaced delay line
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
			taps_q <= '0;
		else if (half_chip_o)
			taps_q <= {taps_q[NUM_COR-2:0], prn_chip_i};	// same-cycle sample sees old taps
	end

endmodule

//--- logic/corr_bank.sv
`timescale 1ns/1ns

module corr_bank import corr_pkg::*; #(
	parameter int NUM_COR = 8	// number of correlators
) (
	input  logic               clk,	// system clock
	input  logic               rst_b,	// async reset, low active
	input  logic               sample_valid_i,	// sample strobe
	input  iq_sample_t         sample_i,	// mixed I/Q sample
	input  logic [NUM_COR-1:0] taps_i,	// chip per correlator, 1 adds
	input  logic [NUM_COR-1:0] clear_sel_i,	// one-hot restart
	input  logic [2:0]         read_sel_i,	// pair to read out
	output iq_acc_t            acc_o	// selected pair
);

	localparam int SEL_W = (NUM_COR > 1) ? $clog2(NUM_COR) : 1;	// used index bits

	logic signed [ACC_W-1:0] pos_i;	// sign extended sample
	logic signed [ACC_W-1:0] pos_q;
	iq_acc_t                 acc_all [NUM_COR];	// every pair, for the read mux

	assign pos_i = sample_valid_i ? {{(ACC_W-SAMPLE_W){sample_i.i[SAMPLE_W-1]}}, sample_i.i} : '0;
	assign pos_q = sample_valid_i ? {{(ACC_W-SAMPLE_W){sample_i.q[SAMPLE_W-1]}}, sample_i.q} : '0;

	//----------------------------------------------------------------------
	// accumulator pairs
	//----------------------------------------------------------------------
	for (genvar k = 0; k < NUM_COR; k++)
	begin : g_acc
		iq_acc_t acc_q;	// running I/Q sums
		iq_acc_t contrib;	// this cycle's +/- sample

		assign contrib.i  = taps_i[k] ? pos_i : -pos_i;	// chip 0 negates
		assign contrib.q  = taps_i[k] ? pos_q : -pos_q;
		assign acc_all[k] = acc_q;

		always_ff @(posedge clk or negedge rst_b)
		begin
			if (!rst_b)
				acc_q <= '0;
			else if (clear_sel_i[k])
				acc_q <= contrib;	// restart from current contribution
			else if (sample_valid_i)
			begin
				acc_q.i <= acc_q.i + contrib.i;	// wraps
				acc_q.q <= acc_q.q + contrib.q;
			end
		end
	end

	assign acc_o = acc_all[read_sel_i[SEL_W-1:0]];	// combinational read

endmodule

//--- logic/corr_pkg.sv
package corr_pkg;

	//----------------------------------------------------------------------
	// widths
	//----------------------------------------------------------------------
	localparam int SAMPLE_W = 6;	// one I or Q sample
	localparam int ACC_W    = 16;	// accumulator and dump width
	localparam int PHASE_W  = 32;	// code nco phase
	localparam int DEC_W    = 32;	// decoded data register

	//----------------------------------------------------------------------
	// data paths
	//----------------------------------------------------------------------
	typedef struct packed {
		logic signed [SAMPLE_W-1:0] i;	// in-phase sample
		logic signed [SAMPLE_W-1:0] q;	// quadrature sample
	} iq_sample_t;

	// one accumulator pair, also the coherent sum (i in upper half)
	typedef struct packed {
		logic signed [ACC_W-1:0] i;	// I sum
		logic signed [ACC_W-1:0] q;	// Q sum
	} iq_acc_t;

	typedef struct packed {
		logic       valid;	// dump strobe
		logic [2:0] index;	// correlator being dumped
		iq_acc_t    sums;	// post-shifted sums
	} dump_out_t;

	//----------------------------------------------------------------------
	// decoder configuration
	//----------------------------------------------------------------------
	typedef struct packed {
		logic [1:0] decode_bit;	// 0..3 -> 1, 2, 4, 8 bits
		logic [1:0] pre_shift;	// shift ahead of accumulation
		logic [1:0] post_shift;	// shift applied to dumped sums
		logic [4:0] bit_length;	// ms per data bit
	} decode_cfg_t;

endpackage

//--- logic/correlator.sv
`timescale 1ns/1ns

module correlator import corr_pkg::*; #(
	parameter int NUM_COR = 8	// correlators per channel
) (
	input  logic               clk,	// system clock
	input  logic               rst_b,	// async reset, low active
	input  logic               sample_valid_i,	// sample strobe
	input  iq_sample_t         sample_i,	// down-converted I/Q
	input  logic [PHASE_W-1:0] code_freq_i,	// code nco increment
	input  logic               prn_chip_i,	// chip from prn source
	input  logic [15:0]        dump_length_i,	// chips per dump
	input  decode_cfg_t        decode_cfg_i,	// decoder settings
	input  logic               data_in_q_i,	// decode from Q
	input  logic               coh_finished_i,	// coherent sum strobe
	input  iq_acc_t            coh_sum_i,	// coherent sum
	output logic               chip_shift_o,	// next chip request
	output dump_out_t          dump_o,	// dumped correlator sums
	output logic [DEC_W-1:0]   decode_data_o	// decoded data bits
);

	logic [NUM_COR-1:0] taps;	// half-chip delayed chips
	logic [NUM_COR-1:0] clear_sel;	// accumulator restart
	logic [2:0]         read_sel;	// accumulator readout
	iq_acc_t            acc_sel;	// selected pair

	//----------------------------------------------------------------------
	// code tracking and correlation
	//----------------------------------------------------------------------
	code_nco #(.NUM_COR(NUM_COR)) code_nco_i (.clk(clk), .rst_b(rst_b),
		.sample_valid_i(sample_valid_i), .code_freq_i(code_freq_i), .prn_chip_i(prn_chip_i),
		.half_chip_o(), .chip_shift_o(chip_shift_o), .taps_o(taps));

	corr_bank #(.NUM_COR(NUM_COR)) corr_bank_i (.clk(clk), .rst_b(rst_b),
		.sample_valid_i(sample_valid_i), .sample_i(sample_i), .taps_i(taps),
		.clear_sel_i(clear_sel), .read_sel_i(read_sel), .acc_o(acc_sel));

	dump_ctrl #(.NUM_COR(NUM_COR)) dump_ctrl_i (.clk(clk), .rst_b(rst_b),
		.chip_shift_i(chip_shift_o), .dump_length_i(dump_length_i),
		.post_shift_i(decode_cfg_i.post_shift), .acc_i(acc_sel),
		.clear_sel_o(clear_sel), .read_sel_o(read_sel), .dump_o(dump_o));

	//----------------------------------------------------------------------
	// navigation data
	//----------------------------------------------------------------------
	bit_decoder bit_decoder_i (.clk(clk), .rst_b(rst_b), .coh_finished_i(coh_finished_i),
		.coh_sum_i(coh_sum_i), .data_in_q_i(data_in_q_i), .decode_cfg_i(decode_cfg_i),
		.decode_data_o(decode_data_o));

endmodule

//--- logic/dump_ctrl.sv
`timescale 1ns/1ns

module dump_ctrl import corr_pkg::*; #(
	parameter int NUM_COR = 8	// length of the dump sequence
) (
	input  logic               clk,	// system clock
	input  logic               rst_b,	// async reset, low active
	input  logic               chip_shift_i,	// one pulse per chip
	input  logic [15:0]        dump_length_i,	// chips per dump, >= 4
	input  logic [1:0]         post_shift_i,	// arithmetic shift of sums
	input  iq_acc_t            acc_i,	// selected accumulator pair
	output logic [NUM_COR-1:0] clear_sel_o,	// one-hot clear, zero when idle
	output logic [2:0]         read_sel_o,	// pair to read
	output dump_out_t          dump_o	// dumped sums
);

	logic [15:0] chip_cnt_q;	// chips since last dump
	logic        dump_start;	// last chip of the dump period
	logic        dumping_q;	// sequence running
	logic [2:0]  cur_q;	// correlator being dumped

	//----------------------------------------------------------------------
	// chip counter
	//----------------------------------------------------------------------
	assign dump_start = chip_shift_i && (16'(chip_cnt_q + 16'd1) == dump_length_i);

	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
			chip_cnt_q <= '0;
		else if (dump_start)
			chip_cnt_q <= '0;	// period complete
		else if (chip_shift_i)
			chip_cnt_q <= chip_cnt_q + 16'd1;
	end

	//----------------------------------------------------------------------
	// dump sequencer
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
		begin
			dumping_q <= 1'b0;
			cur_q     <= '0;
		end
		else if (dumping_q)
		begin
			if (cur_q == 3'(NUM_COR - 1))
			begin
				dumping_q <= 1'b0;	// last pair done
				cur_q     <= '0;
			end
			else
				cur_q <= cur_q + 3'd1;	// one pair per cycle
		end
		else if (dump_start)
			dumping_q <= 1'b1;	// begins next cycle at index 0
	end

	assign read_sel_o  = cur_q;
	assign clear_sel_o = dumping_q ? (NUM_COR'(1) << cur_q) : '0;

	// sums shifted by post_shift, sign kept
	assign dump_o.valid  = dumping_q;
	assign dump_o.index  = cur_q;
	assign dump_o.sums.i = acc_i.i >>> post_shift_i;
	assign dump_o.sums.q = acc_i.q >>> post_shift_i;

endmodule

//--- sim.f
logic/corr_pkg.sv
logic/code_nco.sv
logic/corr_bank.sv
logic/dump_ctrl.sv
logic/bit_decoder.sv
logic/correlator.sv
sim/correlator_props.sv
sim/correlator_tb.sv

//--- sim/correlator_props.sv
`timescale 1ns/1ns

module correlator_props import corr_pkg::*; #(
	parameter int NUM_COR = 8	// dump sequence length
) (
	input logic             clk,
	input logic             rst_b,
	input logic             chip_shift_o,
	input logic             coh_finished_i,
	input dump_out_t        dump_o,
	input logic [DEC_W-1:0] decode_data_o
);

	//----------------------------------------------------------------------
	// dump sequence, index 0 up to NUM_COR-1 on consecutive cycles
	//----------------------------------------------------------------------
	a_dump_first: assert property (@(posedge clk) disable iff (!rst_b)
		$rose(dump_o.valid) |-> dump_o.index == 3'd0)
		else $error("dump sequence did not start at index zero");

	a_dump_next: assert property (@(posedge clk) disable iff (!rst_b)
		dump_o.valid && dump_o.index != 3'(NUM_COR - 1)
		|=> dump_o.valid && dump_o.index == $past(dump_o.index) + 3'd1)
		else $error("dump sequence broke off or skipped an index");

	a_dump_end: assert property (@(posedge clk) disable iff (!rst_b)
		dump_o.valid && dump_o.index == 3'(NUM_COR - 1) |=> !dump_o.valid)
		else $error("dump valid stayed high past the last correlator");

	// decode register and chip request
	a_decode_hold: assert property (@(posedge clk) disable iff (!rst_b)
		decode_data_o != $past(decode_data_o) |-> $past(coh_finished_i))
		else $error("decoded data changed without a coherent sum strobe");

	// two carries per chip, at most one carry per two samples
	a_chip_spacing: assert property (@(posedge clk) disable iff (!rst_b)
		chip_shift_o |-> !$past(chip_shift_o) && !$past(chip_shift_o, 2)
		&& !$past(chip_shift_o, 3))
		else $error("chip requests came closer than four cycles apart");

endmodule

bind correlator correlator_props #(.NUM_COR(NUM_COR)) correlator_props_i (.clk(clk),
	.rst_b(rst_b), .chip_shift_o(chip_shift_o),
	.coh_finished_i(coh_finished_i), .dump_o(dump_o), .decode_data_o(decode_data_o));

//--- sim/correlator_tb.sv
`timescale 1ns/1ns

module correlator_tb import corr_pkg::*; ();

	localparam int NUM_COR      = 8;	// correlators in the dut
	localparam int CLK_PERIOD   = 40;	// ns
	localparam int RESET_CYCLES = 3;
	localparam int NUM_CYCLES   = 4000;	// random stimulus cycles
	localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 200) * CLK_PERIOD;

	logic               clk = 1'b0;
	logic               rst_b;
	logic               sample_valid;
	iq_sample_t         sample;
	logic [PHASE_W-1:0] code_freq;
	logic               prn_chip;
	logic [15:0]        dump_length;
	decode_cfg_t        decode_cfg;
	logic               data_in_q;
	logic               coh_finished;
	iq_acc_t            coh_sum;
	logic               chip_shift_o;
	dump_out_t          dump_o;
	logic [DEC_W-1:0]   decode_data_o;

	//----------------------------------------------------------------------
	// model state
	//----------------------------------------------------------------------
	logic [PHASE_W-1:0]      m_phase;	// code phase
	logic                    m_sub;	// half-chip parity
	logic [NUM_COR-1:0]      m_taps;	// chip delay line
	logic signed [ACC_W-1:0] m_acc_i [NUM_COR];
	logic signed [ACC_W-1:0] m_acc_q [NUM_COR];
	int                      m_cnt;	// chips since last dump
	logic                    m_dumping;
	int                      m_cur;	// pair being dumped
	logic [DEC_W-1:0]        m_dec;	// decoded data
	logic                    exp_half;	// this cycle's carry
	logic                    exp_cs;	// this cycle's chip request
	logic                    chip_due = 1'b1;	// draw a new chip
	logic                    length_due = 1'b1;	// draw new length and freq
	logic [31:0]             lfsr = 32'd77361;

	always #(CLK_PERIOD / 2) clk = ~clk;

	correlator #(.NUM_COR(NUM_COR)) correlator_i (.clk(clk), .rst_b(rst_b),
		.sample_valid_i(sample_valid), .sample_i(sample), .code_freq_i(code_freq),
		.prn_chip_i(prn_chip), .dump_length_i(dump_length), .decode_cfg_i(decode_cfg),
		.data_in_q_i(data_in_q), .coh_finished_i(coh_finished), .coh_sum_i(coh_sum),
		.chip_shift_o(chip_shift_o), .dump_o(dump_o), .decode_data_o(decode_data_o));

	// fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int b = 0; b < n; b++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	// full scale ends now and then, to hit saturation
	function automatic logic signed [ACC_W-1:0] pick_sum();
		logic [31:0] r;
		r = rand_bits(2);
		if (r == 0)
			return 16'sh7fff;
		else if (r == 1)
			return 16'sh8000;
		r = rand_bits(16);
		return r[15:0];
	endfunction

	// quantize to 1/2/4/8 bits and shift into the data word
	function automatic logic [DEC_W-1:0] expected_decode(input logic [DEC_W-1:0] cur,
		input iq_acc_t sum, input logic use_q, input decode_cfg_t cfg);
		int v;
		int w;
		int l;
		int s;
		int hi;
		v = use_q ? int'(sum.q) : int'(sum.i);
		w = 1 << cfg.decode_bit;
		if (w == 1)
			return {cur[DEC_W-2:0], v < 0};	// sign only
		l = cfg.bit_length[4] ? 2 : (cfg.bit_length[3] ? 1 : 0);
		s = int'(cfg.pre_shift) + int'(cfg.post_shift) + 1;
		s = (s < l) ? 0 : s - l;
		v = v >>> (ACC_W - w - s);
		hi = (1 << (w - 1)) - 1;
		if (v > hi)
			v = hi;
		else if (v < -hi - 1)
			v = -hi - 1;
		return (cur << w) | (32'(v) & ((32'd1 << w) - 32'd1));
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("FAILED %s: expected %h, got %h", name, expected, actual);
		$display("TB FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	//----------------------------------------------------------------------
	// stimulus, prediction and model update
	//----------------------------------------------------------------------
	task automatic drive_inputs();
		logic [31:0] r;
		sample_valid = (rand_bits(2) != 0);	// about 3/4 valid
		r            = rand_bits(12);
		sample       = r[11:0];
		if (chip_due)
			prn_chip = (rand_bits(1) != 0);	// next chip after a request
		if (length_due)
		begin
			dump_length = 16'(32'd4 + rand_bits(4) % 32'd9);	// 4..12 chips
			code_freq   = 32'h1000_0000 + rand_bits(31) % 32'h7000_0001;	// 2^28..2^31
		end
		coh_finished = (rand_bits(3) == 0);
		if (coh_finished)
		begin
			r          = rand_bits(11);
			decode_cfg = r[10:0];
			data_in_q  = (rand_bits(1) != 0);
			coh_sum.i  = pick_sum();
			coh_sum.q  = pick_sum();
		end
	endtask

	task automatic check_outputs();
		logic [PHASE_W:0] sum;
		dump_out_t        exp_dump;
		sum             = {1'b0, m_phase} + {1'b0, code_freq};
		exp_half        = sample_valid && sum[PHASE_W];
		exp_cs          = exp_half && m_sub;	// every second boundary
		exp_dump.valid  = m_dumping;
		exp_dump.index  = 3'(m_cur);
		exp_dump.sums.i = m_acc_i[m_cur] >>> decode_cfg.post_shift;
		exp_dump.sums.q = m_acc_q[m_cur] >>> decode_cfg.post_shift;
		assert (chip_shift_o === exp_cs)
		else report_mismatch("chip_shift_o", 64'(exp_cs), 64'(chip_shift_o));
		assert (dump_o === exp_dump)
		else report_mismatch("dump_o", 64'(exp_dump), 64'(dump_o));
		assert (decode_data_o === m_dec)
		else report_mismatch("decode_data_o", 64'(m_dec), 64'(decode_data_o));
	endtask

	task automatic step_model();
		int   ci;
		int   cq;
		logic dump_start;
		for (int k = 0; k < NUM_COR; k++)
		begin
			ci = sample_valid ? int'(sample.i) : 0;
			cq = sample_valid ? int'(sample.q) : 0;
			if (!m_taps[k])
			begin
				ci = -ci;	// chip 0 subtracts
				cq = -cq;
			end
			if (m_dumping && m_cur == k)
			begin
				m_acc_i[k] = ACC_W'(ci);	// restart on dump
				m_acc_q[k] = ACC_W'(cq);
			end
			else
			begin
				m_acc_i[k] = m_acc_i[k] + ACC_W'(ci);
				m_acc_q[k] = m_acc_q[k] + ACC_W'(cq);
			end
		end
		dump_start = exp_cs && (m_cnt + 1 == int'(dump_length));
		if (dump_start)
			m_cnt = 0;
		else if (exp_cs)
			m_cnt++;
		if (m_dumping)
		begin
			if (m_cur == NUM_COR - 1)
			begin
				m_dumping = 1'b0;
				m_cur     = 0;
			end
			else
				m_cur++;
		end
		else if (dump_start)
			m_dumping = 1'b1;
		if (sample_valid)
			m_phase = m_phase + code_freq;	// wraps
		if (exp_half)
		begin
			m_sub  = ~m_sub;
			m_taps = {m_taps[NUM_COR-2:0], prn_chip};	// after the sample used old taps
		end
		if (coh_finished)
			m_dec = expected_decode(m_dec, coh_sum, data_in_q, decode_cfg);
		chip_due   = exp_cs;
		length_due = dump_start;
	endtask

	//----------------------------------------------------------------------
	// main sequence
	//----------------------------------------------------------------------
	initial
	begin
		rst_b        = 1'b0;
		sample_valid = 1'b0;
		sample       = '0;
		code_freq    = '0;
		prn_chip     = 1'b0;
		dump_length  = 16'd4;
		decode_cfg   = '0;
		data_in_q    = 1'b0;
		coh_finished = 1'b0;
		coh_sum      = '0;
		m_phase      = '0;
		m_sub        = 1'b0;
		m_taps       = '0;
		m_cnt        = 0;
		m_dumping    = 1'b0;
		m_cur        = 0;
		m_dec        = '0;
		for (int k = 0; k < NUM_COR; k++)
		begin
			m_acc_i[k] = '0;
			m_acc_q[k] = '0;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst_b = 1'b1;
		#(CLK_PERIOD / 4);
		check_outputs();	// all outputs idle after reset
		for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
		begin
			@(negedge clk);
			drive_inputs();
			#(CLK_PERIOD / 4);	// settled, well before the rising edge
			check_outputs();
			step_model();
		end
		$display("TB PASSED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the test sequence did not finish in time");
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule
